/* all.f */
hdl/lsu_pkg.sv
hdl/lsu_lane_if.sv
hdl/lsu_fsm.sv
hdl/resp_timer.sv
hdl/lane_aligner.sv
hdl/load_extractor.sv
hdl/lsu_top.sv
bench/lsu_properties.sv
bench/lsu_checker.sv
bench/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_lane_if.sv
      - hdl/lsu_fsm.sv
      - hdl/resp_timer.sv
      - hdl/lane_aligner.sv
      - hdl/load_extractor.sv
      - hdl/lsu_top.sv
  - target: simulation
    files:
      - bench/lsu_properties.sv
      - bench/lsu_checker.sv
      - bench/lsu_tb.sv

/* bench/lsu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int HALF_PERIOD = 50;
    localparam int MAX_ROWS    = 40;
    localparam int IDLE_GAP    = 3;

    typedef struct packed {
        logic [8 * 12 - 1:0] name;
        logic                write;
        mem_op_e             op;
        logic [ADDR_W - 1:0] addr;
        logic [DATA_W - 1:0] wdata;
        logic                silent;
        logic [1:0]          resp;
        logic                twice;
        logic                no_bus;
        logic                exp_err;
        logic [DATA_W - 1:0] exp_rdata;
        logic [STRB_W - 1:0] exp_wstrb;
        logic [DATA_W - 1:0] exp_wdata;
    } row_t;

    row_t        rows [MAX_ROWS];
    row_t        cur;
    int          num_rows;
    int          cycle_count;
    int          cycle_limit;
    int          tests;
    int          errors;
    int unsigned seed_value;

    logic                clk;
    logic                rst;
    logic                req;
    logic                req_write;
    mem_op_e             req_op;
    logic [ADDR_W - 1:0] req_addr;
    logic [DATA_W - 1:0] req_wdata;
    logic                busy;
    logic                done;
    logic                err;
    logic [DATA_W - 1:0] rdata;

    logic [ADDR_W - 1:0] m_axi_araddr;
    logic                m_axi_arvalid;
    logic                m_axi_arready;
    logic [DATA_W - 1:0] m_axi_rdata;
    logic [1:0]          m_axi_rresp;
    logic                m_axi_rvalid;
    logic                m_axi_rready;
    logic [ADDR_W - 1:0] m_axi_awaddr;
    logic                m_axi_awvalid;
    logic                m_axi_awready;
    logic [DATA_W - 1:0] m_axi_wdata;
    logic [STRB_W - 1:0] m_axi_wstrb;
    logic                m_axi_wvalid;
    logic                m_axi_wready;
    logic [1:0]          m_axi_bresp;
    logic                m_axi_bvalid;
    logic                m_axi_bready;

    // slave model state
    logic [DATA_W - 1:0] mem [16];
    logic [3:0]          rd_index;
    logic [3:0]          wr_index;
    logic [DATA_W - 1:0] wr_data;
    logic [STRB_W - 1:0] wr_strb;
    int unsigned         rd_delay;
    int unsigned         aw_delay;
    int unsigned         w_delay;
    int unsigned         b_delay;

    lsu_top lsu_top_inst (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_write     (req_write),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .busy          (busy),
        .done          (done),
        .err           (err),
        .rdata         (rdata),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_rdata   (m_axi_rdata),
        .m_axi_rresp   (m_axi_rresp),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wstrb   (m_axi_wstrb),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_bresp   (m_axi_bresp),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready)
    );

    lsu_checker lsu_checker_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .err       (err),
        .rdata     (rdata),
        .arvalid   (m_axi_arvalid),
        .rvalid    (m_axi_rvalid),
        .rready    (m_axi_rready),
        .awvalid   (m_axi_awvalid),
        .wvalid    (m_axi_wvalid),
        .wready    (m_axi_wready),
        .wstrb     (m_axi_wstrb),
        .wdata     (m_axi_wdata),
        .bvalid    (m_axi_bvalid),
        .bready    (m_axi_bready),
        .name      (cur.name),
        .write     (cur.write),
        .silent    (cur.silent),
        .no_bus    (cur.no_bus),
        .exp_err   (cur.exp_err),
        .exp_rdata (cur.exp_rdata),
        .exp_wstrb (cur.exp_wstrb),
        .exp_wdata (cur.exp_wdata),
        .tests     (tests),
        .errors    (errors)
    );

    always #HALF_PERIOD clk = ~clk;

    // --------------------
    // table construction
    // --------------------
    task load_row(input logic [8 * 12 - 1:0] name, input mem_op_e op,
                  input logic [ADDR_W - 1:0] addr, input logic [DATA_W - 1:0] exp_rdata);
        rows[num_rows]           = '0;
        rows[num_rows].name      = name;
        rows[num_rows].op        = op;
        rows[num_rows].addr      = addr;
        rows[num_rows].exp_rdata = exp_rdata;
        num_rows                 = num_rows + 1;
    endtask

    task store_row(input logic [8 * 12 - 1:0] name, input mem_op_e op,
                   input logic [ADDR_W - 1:0] addr, input logic [DATA_W - 1:0] data,
                   input logic [STRB_W - 1:0] exp_wstrb, input logic [DATA_W - 1:0] exp_wdata);
        rows[num_rows]           = '0;
        rows[num_rows].name      = name;
        rows[num_rows].write     = 1'b1;
        rows[num_rows].op        = op;
        rows[num_rows].addr      = addr;
        rows[num_rows].wdata     = data;
        rows[num_rows].exp_wstrb = exp_wstrb;
        rows[num_rows].exp_wdata = exp_wdata;
        num_rows                 = num_rows + 1;
    endtask

    task set_error_resp(input logic [1:0] resp);
        rows[num_rows - 1].resp    = resp;
        rows[num_rows - 1].exp_err = 1'b1;
    endtask

    task make_silent();
        rows[num_rows - 1].silent  = 1'b1;
        rows[num_rows - 1].exp_err = 1'b1;
    endtask

    task flag_misaligned();
        rows[num_rows - 1].no_bus  = 1'b1;
        rows[num_rows - 1].exp_err = 1'b1;
    endtask

    task build_table();
        num_rows = 0;
        // slave word i preloads as 0x8000_0000 + i * 0x0102_0304
        load_row("lb_off0", OP_B, 32'h08, 32'h0000_0008);
        load_row("lb_off1", OP_B, 32'h09, 32'h0000_0006);
        load_row("lb_off2", OP_B, 32'h0A, 32'h0000_0004);
        load_row("lb_off3", OP_B, 32'h0B, 32'hFFFF_FF82);
        load_row("lbu_off0", OP_BU, 32'h08, 32'h0000_0008);
        load_row("lbu_off1", OP_BU, 32'h09, 32'h0000_0006);
        load_row("lbu_off2", OP_BU, 32'h0A, 32'h0000_0004);
        load_row("lbu_off3", OP_BU, 32'h0B, 32'h0000_0082);
        load_row("lh_off0", OP_H, 32'h0C, 32'h0000_090C);
        load_row("lh_off2", OP_H, 32'h0E, 32'hFFFF_8306);
        load_row("lhu_off0", OP_HU, 32'h0C, 32'h0000_090C);
        load_row("lhu_off2", OP_HU, 32'h0E, 32'h0000_8306);
        load_row("lw_off0", OP_W, 32'h10, 32'h8408_0C10);
        store_row("sb_off1", OP_B, 32'h15, 32'h0000_00A5, 4'b0010, 32'hA5A5_A5A5);
        load_row("lw_after_sb", OP_W, 32'h14, 32'h850A_A514);
        store_row("sh_off2", OP_H, 32'h1A, 32'h1234_BEEF, 4'b1100, 32'hBEEF_BEEF);
        load_row("lh_after_sh", OP_H, 32'h1A, 32'hFFFF_BEEF);
        load_row("lw_after_sh", OP_W, 32'h18, 32'hBEEF_1218);
        store_row("sw_off0", OP_W, 32'h1C, 32'hCAFE_F00D, 4'b1111, 32'hCAFE_F00D);
        load_row("lw_after_sw", OP_W, 32'h1C, 32'hCAFE_F00D);
        // unsigned op on a store behaves as a plain byte store
        store_row("sbu_off3", OP_BU, 32'h23, 32'h0000_005A, 4'b1000, 32'h5A5A_5A5A);
        load_row("lw_after_sbu", OP_W, 32'h20, 32'h5A10_1820);
        load_row("lh_misalign", OP_H, 32'h05, 32'h5A10_1820);
        flag_misaligned();
        load_row("lw_misalign", OP_W, 32'h06, 32'h5A10_1820);
        flag_misaligned();
        store_row("sh_misalign", OP_H, 32'h03, 32'h0000_1111, 4'b0000, 32'h0);
        flag_misaligned();
        store_row("sw_misalign", OP_W, 32'h0B, 32'h2222_2222, 4'b0000, 32'h0);
        flag_misaligned();
        load_row("lw_rresp_err", OP_W, 32'h00, 32'h5A10_1820);
        set_error_resp(2'b10);
        store_row("sw_bresp_err", OP_W, 32'h24, 32'h1122_3344, 4'b1111, 32'h1122_3344);
        set_error_resp(2'b11);
        load_row("lw_silent", OP_W, 32'h28, 32'h5A10_1820);
        make_silent();
        store_row("sw_silent", OP_W, 32'h2C, 32'h5555_AAAA, 4'b1111, 32'h5555_AAAA);
        make_silent();
        load_row("lw_twice", OP_W, 32'h30, 32'h8C18_2430);
        rows[num_rows - 1].twice = 1'b1;
        load_row("lw_final", OP_W, 32'h04, 32'h8102_0304);
    endtask

    // --------------------
    // stimulus on the falling edge
    // --------------------
    task apply_row(input row_t row);
        @(negedge clk);
        cur       = row;
        req       = 1'b1;
        req_write = row.write;
        req_op    = row.op;
        req_addr  = row.addr;
        req_wdata = row.wdata;
        @(negedge clk);
        req = 1'b0;
        if (row.twice) begin
            // second strobe lands while the first is in flight
            req_write = 1'b0;
            req_op    = OP_W;
            req_addr  = row.addr + 32'h4;
            req       = 1'b1;
            @(negedge clk);
            req = 1'b0;
        end
        while (!done) begin
            @(negedge clk);
        end
        repeat (IDLE_GAP) @(negedge clk);
    endtask

    // --------------------
    // AXI4-Lite slave model
    // --------------------
    always begin
        @(negedge clk);
        if (!rst && m_axi_arvalid && !cur.silent) begin
            rd_delay = $urandom % 4;
            repeat (rd_delay) @(negedge clk);
            rd_index      = m_axi_araddr[5:2];
            m_axi_arready = 1'b1;
            @(negedge clk);
            m_axi_arready = 1'b0;
            rd_delay      = $urandom % 4;
            repeat (rd_delay) @(negedge clk);
            m_axi_rdata  = mem[rd_index];
            m_axi_rresp  = cur.resp;
            m_axi_rvalid = 1'b1;
            // rready is already up in the data phase
            @(negedge clk);
            m_axi_rvalid = 1'b0;
        end
    end

    always begin
        @(negedge clk);
        if (!rst && m_axi_awvalid && !cur.silent) begin
            wr_index = m_axi_awaddr[5:2];
            aw_delay = $urandom % 4;
            w_delay  = $urandom % 4;
            fork
                begin
                    repeat (aw_delay) @(negedge clk);
                    m_axi_awready = 1'b1;
                    @(negedge clk);
                    m_axi_awready = 1'b0;
                end
                begin
                    repeat (w_delay) @(negedge clk);
                    wr_data      = m_axi_wdata;
                    wr_strb      = m_axi_wstrb;
                    m_axi_wready = 1'b1;
                    @(negedge clk);
                    m_axi_wready = 1'b0;
                end
            join
            if (cur.resp == RESP_OKAY) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_index][8 * b +: 8] = wr_data[8 * b +: 8];
                    end
                end
            end
            b_delay = $urandom % 4;
            repeat (b_delay) @(negedge clk);
            m_axi_bresp  = cur.resp;
            m_axi_bvalid = 1'b1;
            @(negedge clk);
            m_axi_bvalid = 1'b0;
        end
    end

    initial begin
        seed_value    = $urandom(88956);
        clk           = 1'b0;
        rst           = 1'b1;
        req           = 1'b0;
        req_write     = 1'b0;
        req_op        = OP_W;
        req_addr      = '0;
        req_wdata     = '0;
        m_axi_arready = 1'b0;
        m_axi_rdata   = '0;
        m_axi_rresp   = RESP_OKAY;
        m_axi_rvalid  = 1'b0;
        m_axi_awready = 1'b0;
        m_axi_wready  = 1'b0;
        m_axi_bresp   = RESP_OKAY;
        m_axi_bvalid  = 1'b0;
        cur           = '0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = 32'h8000_0000 + i * 32'h0102_0304;
        end
        build_table();
        cycle_limit = num_rows * (RESP_TIMEOUT + 12) + 20;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            apply_row(rows[r]);
        end
        $display("%0d tests run, %0d failed", tests, errors);
        if (errors == 0 && tests == num_rows) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // run limit scaled to the table
    initial begin
        cycle_count = 0;
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("run stopped after %0d cycles without finishing the table", cycle_limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/lsu_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_checker
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  logic                busy,
    input  logic                done,
    input  logic                err,
    input  logic [DATA_W - 1:0] rdata,
    input  logic                arvalid,
    input  logic                rvalid,
    input  logic                rready,
    input  logic                awvalid,
    input  logic                wvalid,
    input  logic                wready,
    input  logic [STRB_W - 1:0] wstrb,
    input  logic [DATA_W - 1:0] wdata,
    input  logic                bvalid,
    input  logic                bready,

    // expectations of the current table row
    input  logic [8 * 12 - 1:0] name,
    input  logic                write,
    input  logic                silent,
    input  logic                no_bus,
    input  logic                exp_err,
    input  logic [DATA_W - 1:0] exp_rdata,
    input  logic [STRB_W - 1:0] exp_wstrb,
    input  logic [DATA_W - 1:0] exp_wdata,
    output int                  tests,
    output int                  errors
);

    logic                waiting;
    logic                test_bad;
    logic                got_w;
    logic                got_r;
    logic                got_b;
    logic                busy_seen;
    logic [STRB_W - 1:0] seen_wstrb;
    logic [DATA_W - 1:0] seen_wdata;
    int                  wait_cycles;
    int                  bus_cycles;

    task compare_value(input string field, input logic [DATA_W - 1:0] expected,
                       input logic [DATA_W - 1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %0s %0s expected %h, actual %h", name, field, expected, actual);
            test_bad = 1'b1;
        end
    endtask

    task close_test();
        test_bad = 1'b0;
        compare_value("err", {31'b0, exp_err}, {31'b0, err});
        if (!write) begin
            compare_value("rdata", exp_rdata, rdata);
        end
        if (!write && !silent && !no_bus && !got_r) begin
            $display("test %0s: the read data handshake never happened", name);
            test_bad = 1'b1;
        end
        if (write && !silent && !no_bus) begin
            if (!got_w) begin
                $display("test %0s: the write data handshake never happened", name);
                test_bad = 1'b1;
            end else begin
                compare_value("wstrb", {28'b0, exp_wstrb}, {28'b0, seen_wstrb});
                compare_value("wdata", exp_wdata, seen_wdata);
            end
            if (!got_b) begin
                $display("test %0s: the write response handshake never happened", name);
                test_bad = 1'b1;
            end
        end
        if (no_bus && bus_cycles != 0) begin
            $display("test %0s: a bus valid was raised for a rejected request", name);
            test_bad = 1'b1;
        end
        if (no_bus && busy_seen) begin
            $display("test %0s: busy rose for a rejected request", name);
            test_bad = 1'b1;
        end
        if (!no_bus && !busy_seen) begin
            $display("test %0s: busy never rose during the transaction", name);
            test_bad = 1'b1;
        end
        if (busy) begin
            $display("test %0s: busy still high in the done cycle", name);
            test_bad = 1'b1;
        end
        tests = tests + 1;
        if (test_bad) begin
            errors = errors + 1;
        end
        $display("test %0s: %0s", name, test_bad ? "failed" : "ok");
        waiting = 1'b0;
    endtask

    // --------------------
    // sampling at the rising edge
    // --------------------
    always @(posedge clk) begin
        if (rst) begin
            waiting   = 1'b0;
            got_w     = 1'b0;
            got_r     = 1'b0;
            got_b     = 1'b0;
            busy_seen = 1'b0;
            tests     = 0;
            errors    = 0;
        end else begin
            if (rvalid && rready) begin
                got_r = 1'b1;
            end
            if (wvalid && wready) begin
                got_w      = 1'b1;
                seen_wstrb = wstrb;
                seen_wdata = wdata;
            end
            if (bvalid && bready) begin
                got_b = 1'b1;
            end
            if (waiting && busy) begin
                busy_seen = 1'b1;
            end
            if (waiting && (arvalid || awvalid || wvalid)) begin
                bus_cycles = bus_cycles + 1;
            end
            if (done) begin
                if (waiting) begin
                    close_test();
                end else begin
                    $display("test %0s: an extra done strobe arrived", name);
                    errors = errors + 1;
                end
            end else if (waiting) begin
                wait_cycles = wait_cycles + 1;
                if (wait_cycles > RESP_TIMEOUT + 2) begin
                    $display("test %0s: no done within %0d cycles", name, RESP_TIMEOUT + 2);
                    tests   = tests + 1;
                    errors  = errors + 1;
                    waiting = 1'b0;
                end
            end else if (req && !busy) begin
                // request taken by the unit
                waiting     = 1'b1;
                wait_cycles = 0;
                bus_cycles  = 0;
                got_w       = 1'b0;
                got_r       = 1'b0;
                got_b       = 1'b0;
                busy_seen   = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/lsu_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_properties
    import lsu_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input lsu_state_e state,
    input logic       done,
    input logic       expired,
    input logic       arvalid,
    input logic       arready,
    input logic       awvalid,
    input logic       wvalid
);

    // done is a one-cycle strobe
    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for two cycles");

    // read address stays up until taken or abandoned
    arvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid && !arready && !expired) |=> arvalid)
        else $error("arvalid dropped before arready or expiry");

    // only one kind of transaction at a time
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid))
        else $error("arvalid and awvalid high together");

    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (state == ST_IDLE) |-> !(arvalid || awvalid || wvalid))
        else $error("bus valid raised while idle");

endmodule

bind lsu_fsm lsu_properties lsu_properties_inst (
    .clk     (clk),
    .rst     (rst),
    .state   (state),
    .done    (done),
    .expired (expired),
    .arvalid (arvalid),
    .arready (arready),
    .awvalid (awvalid),
    .wvalid  (wvalid)
);

`default_nettype wire

/* hdl/lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    // requester side
    input  logic                req,
    input  logic                req_write,
    input  mem_op_e             req_op,
    input  logic [ADDR_W - 1:0] req_addr,
    input  logic [DATA_W - 1:0] req_wdata,
    output logic                busy,
    output logic                done,
    output logic                err,
    output logic [DATA_W - 1:0] rdata,

    // AXI4-Lite read channels
    output logic [ADDR_W - 1:0] m_axi_araddr,
    output logic                m_axi_arvalid,
    input  logic                m_axi_arready,
    input  logic [DATA_W - 1:0] m_axi_rdata,
    input  logic [1:0]          m_axi_rresp,
    input  logic                m_axi_rvalid,
    output logic                m_axi_rready,

    // AXI4-Lite write channels
    output logic [ADDR_W - 1:0] m_axi_awaddr,
    output logic                m_axi_awvalid,
    input  logic                m_axi_awready,
    output logic [DATA_W - 1:0] m_axi_wdata,
    output logic [STRB_W - 1:0] m_axi_wstrb,
    output logic                m_axi_wvalid,
    input  logic                m_axi_wready,
    input  logic [1:0]          m_axi_bresp,
    input  logic                m_axi_bvalid,
    output logic                m_axi_bready
);

    logic timer_run;
    logic expired;

    lsu_lane_if lane_if ();

    lsu_fsm lsu_fsm_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_write (req_write),
        .lane      (lane_if.fsm),
        .expired   (expired),
        .timer_run (timer_run),
        .arvalid   (m_axi_arvalid),
        .arready   (m_axi_arready),
        .rvalid    (m_axi_rvalid),
        .rresp     (m_axi_rresp),
        .rready    (m_axi_rready),
        .awvalid   (m_axi_awvalid),
        .awready   (m_axi_awready),
        .wvalid    (m_axi_wvalid),
        .wready    (m_axi_wready),
        .bvalid    (m_axi_bvalid),
        .bresp     (m_axi_bresp),
        .bready    (m_axi_bready),
        .busy      (busy),
        .done      (done),
        .err       (err)
    );

    resp_timer resp_timer_inst (
        .clk     (clk),
        .rst     (rst),
        .run     (timer_run),
        .expired (expired)
    );

    lane_aligner lane_aligner_inst (
        .clk       (clk),
        .rst       (rst),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .lane      (lane_if.aligner),
        .araddr    (m_axi_araddr),
        .awaddr    (m_axi_awaddr),
        .wdata     (m_axi_wdata),
        .wstrb     (m_axi_wstrb)
    );

    load_extractor load_extractor_inst (
        .clk       (clk),
        .rst       (rst),
        .bus_rdata (m_axi_rdata),
        .lane      (lane_if.extractor),
        .rdata     (rdata)
    );

endmodule

`default_nettype wire

/* hdl/load_extractor.sv */
`timescale 1ns/100ps
`default_nettype none

module load_extractor
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [DATA_W - 1:0] bus_rdata,
    lsu_lane_if.extractor       lane,
    output logic [DATA_W - 1:0] rdata
);

    logic [DATA_W - 1:0] shifted;
    logic [DATA_W - 1:0] result;

    // addressed lane down to bit 0
    assign shifted = bus_rdata >> {lane.byte_off, 3'b000};

    always_comb begin
        case (lane.op)
            OP_B:    result = {{24{shifted[7]}}, shifted[7:0]};
            OP_BU:   result = {24'b0, shifted[7:0]};
            OP_H:    result = {{16{shifted[15]}}, shifted[15:0]};
            OP_HU:   result = {16'b0, shifted[15:0]};
            default: result = shifted;
        endcase
    end

    // result register, holds until the next good load
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (lane.capture) begin
            rdata <= result;
        end
    end

endmodule

`default_nettype wire

/* hdl/lane_aligner.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_aligner
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  mem_op_e             req_op,
    input  logic [ADDR_W - 1:0] req_addr,
    input  logic [DATA_W - 1:0] req_wdata,
    lsu_lane_if.aligner         lane,
    output logic [ADDR_W - 1:0] araddr,
    output logic [ADDR_W - 1:0] awaddr,
    output logic [DATA_W - 1:0] wdata,
    output logic [STRB_W - 1:0] wstrb
);

    logic [ADDR_W - 1:0] addr_q;
    logic [DATA_W - 1:0] wdata_d;
    logic [STRB_W - 1:0] wstrb_d;

    assign araddr = addr_q;
    assign awaddr = addr_q;

    // --------------------
    // request decode
    // --------------------
    always_comb begin
        case (req_op)
            OP_B, OP_BU: begin
                wdata_d         = {4{req_wdata[7:0]}};
                wstrb_d         = 4'b0001 << req_addr[1:0];
                lane.misaligned = 1'b0;
            end
            OP_H, OP_HU: begin
                wdata_d         = {2{req_wdata[15:0]}};
                wstrb_d         = 4'b0011 << req_addr[1:0];
                lane.misaligned = req_addr[0];
            end
            default: begin
                wdata_d         = req_wdata;
                wstrb_d         = 4'b1111;
                lane.misaligned = |req_addr[1:0];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lane.op       <= OP_W;
            lane.byte_off <= 2'b00;
            wstrb         <= '0;
        end else if (lane.accept) begin
            lane.op       <= req_op;
            lane.byte_off <= req_addr[1:0];
            wstrb         <= wstrb_d;
        end
    end

    // word address and store data
    always_ff @(posedge clk) begin
        if (lane.accept) begin
            addr_q <= {req_addr[ADDR_W - 1:2], 2'b00};
            wdata  <= wdata_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/resp_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module resp_timer
    import lsu_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic expired
);

    // wide enough to hold RESP_TIMEOUT itself
    logic [$clog2(RESP_TIMEOUT + 1) - 1:0] count;

    assign expired = (count == RESP_TIMEOUT);

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            count <= '0;
        end else if (!expired) begin
            // saturates at the limit
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/lsu_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_fsm
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  logic       req_write,
    lsu_lane_if.fsm    lane,
    input  logic       expired,
    output logic       timer_run,
    output logic       arvalid,
    input  logic       arready,
    input  logic       rvalid,
    input  logic [1:0] rresp,
    output logic       rready,
    output logic       awvalid,
    input  logic       awready,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid,
    input  logic [1:0] bresp,
    output logic       bready,
    output logic       busy,
    output logic       done,
    output logic       err
);

    lsu_state_e state;

    // write channel handshakes seen so far
    logic aw_done;
    logic w_done;
    logic aw_ok;
    logic w_ok;

    assign busy      = (state != ST_IDLE);
    assign timer_run = busy;

    assign arvalid = (state == ST_RD_ADDR);
    assign rready  = (state == ST_RD_DATA);
    assign awvalid = (state == ST_WR_REQ) && !aw_done;
    assign wvalid  = (state == ST_WR_REQ) && !w_done;
    assign bready  = (state == ST_WR_RESP);

    assign aw_ok = aw_done || (awvalid && awready);
    assign w_ok  = w_done || (wvalid && wready);

    assign lane.accept  = req && (state == ST_IDLE);
    // error responses leave the previous load result in place
    assign lane.capture = rready && rvalid && (rresp == RESP_OKAY);

    // --------------------
    // transaction sequencing
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            done    <= 1'b0;
            err     <= 1'b0;
        end else begin
            done <= 1'b0;
            err  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (lane.accept) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        if (lane.misaligned) begin
                            // reject without touching the bus
                            done <= 1'b1;
                            err  <= 1'b1;
                        end else if (req_write) begin
                            state <= ST_WR_REQ;
                        end else begin
                            state <= ST_RD_ADDR;
                        end
                    end
                end
                ST_RD_ADDR: begin
                    if (expired) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                        err   <= 1'b1;
                    end else if (arready) begin
                        state <= ST_RD_DATA;
                    end
                end
                ST_RD_DATA: begin
                    if (rvalid || expired) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                        err   <= expired || (rresp != RESP_OKAY);
                    end
                end
                ST_WR_REQ: begin
                    if (expired) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                        err   <= 1'b1;
                    end else begin
                        aw_done <= aw_ok;
                        w_done  <= w_ok;
                        // both channels through, wait for the response
                        if (aw_ok && w_ok) begin
                            state <= ST_WR_RESP;
                        end
                    end
                end
                ST_WR_RESP: begin
                    if (bvalid || expired) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                        err   <= expired || (bresp != RESP_OKAY);
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/lsu_lane_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface lsu_lane_if
    import lsu_pkg::*;
();

    // strobes from the state machine
    logic    accept;
    logic    capture;

    // request decode from the aligner
    logic       misaligned;
    mem_op_e    op;
    logic [1:0] byte_off;

    modport fsm (output accept, output capture, input misaligned);
    modport aligner (input accept, output misaligned, output op, output byte_off);
    modport extractor (input capture, input op, input byte_off);

endinterface

`default_nettype wire

/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // cycles from acceptance until the unit gives up on the slave
    localparam int RESP_TIMEOUT = 16;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // RISC-V funct3 codes for loads and stores
    typedef enum logic [2:0] {
        OP_B  = 3'b000,
        OP_H  = 3'b001,
        OP_W  = 3'b010,
        OP_BU = 3'b100,
        OP_HU = 3'b101
    } mem_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_DATA,
        ST_WR_REQ,
        ST_WR_RESP
    } lsu_state_e;

endpackage

`default_nettype wire
